//--- kinpira_pkg.sv
`default_nettype none

package kinpira_pkg;

  // Word and memory sizes
  localparam int DWIDTH         = 16;
  localparam int BWIDTH         = 32;
  localparam int LWIDTH         = 16;
  localparam int IMGSIZE        = 10;
  localparam int GOBOU_NETSIZE  = 10;
  localparam int RENKON_NETSIZE = 6;
  localparam int ACCWIDTH       = 40;

  // Fixed point position of the products
  localparam int FRAC = 8;

  localparam logic WHICH_RENKON = 1'b0;
  localparam logic WHICH_GOBOU  = 1'b1;

  typedef logic signed [DWIDTH-1:0] img_word_t;
  typedef logic signed [DWIDTH-1:0] net_word_t;
  typedef logic [IMGSIZE-1:0]       img_addr_t;
  typedef logic [LWIDTH-1:0]        len_t;

  // Shift back to the word scale, optional ReLU, then truncate
  function automatic img_word_t activate(input logic signed [ACCWIDTH-1:0] sum,
                                         input logic relu);
    logic signed [ACCWIDTH-1:0] shifted;
    shifted = sum >>> FRAC;
    if (relu && shifted < 0) begin
      shifted = '0;
    end
    return shifted[DWIDTH-1:0];
  endfunction

endpackage

`default_nettype wire

//--- kinpira_regs_pkg.sv
`default_nettype none

package kinpira_regs_pkg;

  localparam int REG_AWIDTH = 5;

  // Host writable registers
  localparam logic [REG_AWIDTH-1:0] REG_WHICH      = 0;
  localparam logic [REG_AWIDTH-1:0] REG_REQ        = 1;
  localparam logic [REG_AWIDTH-1:0] REG_IN_OFFSET  = 2;
  localparam logic [REG_AWIDTH-1:0] REG_OUT_OFFSET = 3;
  localparam logic [REG_AWIDTH-1:0] REG_NET_OFFSET = 4;

  // total_out high half, total_in low half
  localparam logic [REG_AWIDTH-1:0] REG_BASE0      = 9;
  // img_size low half
  localparam logic [REG_AWIDTH-1:0] REG_BASE1      = 10;
  // conv_size high half
  localparam logic [REG_AWIDTH-1:0] REG_CONV       = 11;
  localparam logic [REG_AWIDTH-1:0] REG_BIAS       = 12;
  localparam logic [REG_AWIDTH-1:0] REG_ACTV       = 13;

  // Read only status
  localparam logic [REG_AWIDTH-1:0] REG_STAT_ACK   = 30;
  localparam logic [REG_AWIDTH-1:0] REG_STAT_WHICH = 31;

  // Enable flag in the bias and activation registers
  localparam int ENABLE_BIT = 31;

endpackage

`default_nettype wire

//--- mem_sp.sv
`timescale 1ns/100ps
`default_nettype none

module mem_sp #(
  parameter type word_t = logic [15:0],
  parameter int  AWIDTH = 10
) (
  input  wire              clk,
  input  wire              mem_we,
  input  wire [AWIDTH-1:0] mem_addr,
  input  wire word_t       mem_wdata,
  output word_t            mem_rdata
);

  word_t mem [2**AWIDTH];

  // Read returns the old word on a write cycle
  always_ff @(posedge clk) begin
    if (mem_we) begin
      mem[mem_addr] <= mem_wdata;
    end
    mem_rdata <= mem[mem_addr];
  end

endmodule

`default_nettype wire

//--- kinpira_regs.sv
`timescale 1ns/100ps
`default_nettype none

module kinpira_regs (
  input  wire                                    clk,
  input  wire                                    xrst,
  input  wire                                    reg_we,
  input  wire [kinpira_regs_pkg::REG_AWIDTH-1:0] reg_addr,
  input  wire [kinpira_pkg::BWIDTH-1:0]          reg_wdata,
  input  wire                                    ack,
  input  wire                                    which_q,
  output logic [kinpira_pkg::BWIDTH-1:0]         reg_rdata,
  output logic                                   which,
  output logic                                   req,
  output kinpira_pkg::img_addr_t                 in_offset,
  output kinpira_pkg::img_addr_t                 out_offset,
  output kinpira_pkg::img_addr_t                 net_offset,
  output kinpira_pkg::len_t                      total_out,
  output kinpira_pkg::len_t                      total_in,
  output kinpira_pkg::len_t                      img_size,
  output kinpira_pkg::len_t                      conv_size,
  output logic                                   bias_en,
  output logic                                   relu_en
);
  import kinpira_pkg::*;
  import kinpira_regs_pkg::*;

  logic [BWIDTH-1:0] which_r;
  logic [BWIDTH-1:0] req_r;
  logic [BWIDTH-1:0] in_off_r;
  logic [BWIDTH-1:0] out_off_r;
  logic [BWIDTH-1:0] net_off_r;
  logic [BWIDTH-1:0] base0_r;
  logic [BWIDTH-1:0] base1_r;
  logic [BWIDTH-1:0] conv_r;
  logic [BWIDTH-1:0] bias_r;
  logic [BWIDTH-1:0] actv_r;

  // Engine control
  always_ff @(posedge clk) begin
    if (!xrst) begin
      which_r <= '0;
      req_r   <= '0;
    end else if (reg_we) begin
      case (reg_addr)
        REG_WHICH: which_r <= reg_wdata;
        REG_REQ:   req_r   <= reg_wdata;
        default: ;
      endcase
    end
  end

  // Layer settings
  always_ff @(posedge clk) begin
    if (reg_we) begin
      case (reg_addr)
        REG_IN_OFFSET:  in_off_r  <= reg_wdata;
        REG_OUT_OFFSET: out_off_r <= reg_wdata;
        REG_NET_OFFSET: net_off_r <= reg_wdata;
        REG_BASE0:      base0_r   <= reg_wdata;
        REG_BASE1:      base1_r   <= reg_wdata;
        REG_CONV:       conv_r    <= reg_wdata;
        REG_BIAS:       bias_r    <= reg_wdata;
        REG_ACTV:       actv_r    <= reg_wdata;
        default: ;
      endcase
    end
  end

  always_comb begin
    case (reg_addr)
      REG_WHICH:      reg_rdata = which_r;
      REG_REQ:        reg_rdata = req_r;
      REG_IN_OFFSET:  reg_rdata = in_off_r;
      REG_OUT_OFFSET: reg_rdata = out_off_r;
      REG_NET_OFFSET: reg_rdata = net_off_r;
      REG_BASE0:      reg_rdata = base0_r;
      REG_BASE1:      reg_rdata = base1_r;
      REG_CONV:       reg_rdata = conv_r;
      REG_BIAS:       reg_rdata = bias_r;
      REG_ACTV:       reg_rdata = actv_r;
      REG_STAT_ACK:   reg_rdata = BWIDTH'(ack);
      REG_STAT_WHICH: reg_rdata = BWIDTH'(which_q);
      default:        reg_rdata = '0;
    endcase
  end

  assign which      = which_r[0];
  assign req        = req_r[0];
  assign in_offset  = in_off_r[IMGSIZE-1:0];
  assign out_offset = out_off_r[IMGSIZE-1:0];
  assign net_offset = net_off_r[IMGSIZE-1:0];
  assign total_out  = base0_r[2*LWIDTH-1:LWIDTH];
  assign total_in   = base0_r[LWIDTH-1:0];
  assign img_size   = base1_r[LWIDTH-1:0];
  assign conv_size  = conv_r[2*LWIDTH-1:LWIDTH];
  assign bias_en    = bias_r[ENABLE_BIT];
  assign relu_en    = actv_r[ENABLE_BIT];

  // Status words are read only
  a_no_stat_write: assert property (@(posedge clk) disable iff (!xrst)
    reg_we |-> (reg_addr != REG_STAT_ACK && reg_addr != REG_STAT_WHICH));

endmodule

`default_nettype wire

//--- gobou_core.sv
`timescale 1ns/100ps
`default_nettype none

module gobou_core (
  input  wire                                   clk,
  input  wire                                   xrst,
  input  wire                                   req,
  input  wire kinpira_pkg::img_addr_t           in_offset,
  input  wire kinpira_pkg::img_addr_t           out_offset,
  input  wire [kinpira_pkg::GOBOU_NETSIZE-1:0]  net_offset,
  input  wire kinpira_pkg::len_t                total_out,
  input  wire kinpira_pkg::len_t                total_in,
  input  wire                                   bias_en,
  input  wire                                   relu_en,
  input  wire kinpira_pkg::img_word_t           img_rdata,
  input  wire kinpira_pkg::net_word_t           net_rdata,
  output logic                                  ack,
  output logic                                  img_we,
  output kinpira_pkg::img_addr_t                img_addr,
  output kinpira_pkg::img_word_t                img_wdata,
  output logic [kinpira_pkg::GOBOU_NETSIZE-1:0] net_addr
);
  import kinpira_pkg::*;

  typedef enum logic [2:0] {S_IDLE, S_MAC, S_BIAS, S_SUM, S_WR, S_ACK} state_t;

  state_t                     state;
  logic                       req_q;
  logic                       mac_v;
  len_t                       i;
  len_t                       j;
  logic [GOBOU_NETSIZE-1:0]   w_ptr;
  logic signed [ACCWIDTH-1:0] acc;
  net_word_t                  bias;

  // ==========================================================================
  // Addressing
  // ==========================================================================

  assign ack      = state == S_ACK;
  assign img_we   = state == S_WR;
  assign img_addr = img_we ? out_offset + IMGSIZE'(j) : in_offset + IMGSIZE'(i);

  // Weights are row major, biases follow the whole matrix
  assign net_addr = (state == S_BIAS)
                  ? net_offset + GOBOU_NETSIZE'(total_out * total_in + j)
                  : w_ptr;

  assign bias = bias_en ? net_rdata : net_word_t'(0);

  // ==========================================================================
  // Control
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state <= S_IDLE;
      req_q <= 1'b0;
      mac_v <= 1'b0;
    end else begin
      req_q <= req;
      mac_v <= state == S_MAC;
      case (state)
        S_IDLE: if (req && !req_q) state <= S_MAC;
        S_MAC:  if (i == total_in - 1) state <= S_BIAS;
        S_BIAS: state <= S_SUM;
        S_SUM:  state <= S_WR;
        S_WR:   state <= (j == total_out - 1) ? S_ACK : S_MAC;
        S_ACK:  if (!req) state <= S_IDLE;
        default: state <= S_IDLE;
      endcase
    end
  end

  // ==========================================================================
  // Datapath
  // ==========================================================================

  always_ff @(posedge clk) begin
    case (state)
      S_IDLE: begin
        i     <= '0;
        j     <= '0;
        w_ptr <= net_offset;
        acc   <= '0;
      end
      S_MAC: begin
        i     <= i + 1'b1;
        w_ptr <= w_ptr + 1'b1;
      end
      S_SUM: img_wdata <= activate(acc + bias, relu_en);
      S_WR: begin
        i   <= '0;
        j   <= j + 1'b1;
        acc <= '0;
      end
      default: ;
    endcase
    // Product of the read issued one cycle earlier
    if (mac_v) begin
      acc <= acc + img_rdata * net_rdata;
    end
  end

  // Writes stay inside the window the engine owns
  a_no_write_on_ack: assert property (@(posedge clk) disable iff (!xrst)
    img_we |-> req && !ack);

endmodule

`default_nettype wire

//--- renkon_core.sv
`timescale 1ns/100ps
`default_nettype none

module renkon_core (
  input  wire                                    clk,
  input  wire                                    xrst,
  input  wire                                    req,
  input  wire kinpira_pkg::img_addr_t            in_offset,
  input  wire kinpira_pkg::img_addr_t            out_offset,
  input  wire [kinpira_pkg::RENKON_NETSIZE-1:0]  net_offset,
  input  wire kinpira_pkg::len_t                 img_size,
  input  wire kinpira_pkg::len_t                 conv_size,
  input  wire                                    bias_en,
  input  wire                                    relu_en,
  input  wire kinpira_pkg::img_word_t            img_rdata,
  input  wire kinpira_pkg::net_word_t            net_rdata,
  output logic                                   ack,
  output logic                                   img_we,
  output kinpira_pkg::img_addr_t                 img_addr,
  output kinpira_pkg::img_word_t                 img_wdata,
  output logic [kinpira_pkg::RENKON_NETSIZE-1:0] net_addr
);
  import kinpira_pkg::*;

  typedef enum logic [2:0] {S_IDLE, S_MAC, S_BIAS, S_SUM, S_WR, S_ACK} state_t;

  state_t                     state;
  logic                       req_q;
  logic                       mac_v;
  len_t                       k;
  len_t                       t;
  logic signed [ACCWIDTH-1:0] acc;
  net_word_t                  bias;

  // ==========================================================================
  // Addressing
  // ==========================================================================

  assign ack      = state == S_ACK;
  assign img_we   = state == S_WR;
  assign img_addr = img_we ? out_offset + IMGSIZE'(k) : in_offset + IMGSIZE'(k + t);

  // Kernel taps first, the bias word right after them
  assign net_addr = (state == S_BIAS)
                  ? net_offset + RENKON_NETSIZE'(conv_size)
                  : net_offset + RENKON_NETSIZE'(t);

  assign bias = bias_en ? net_rdata : net_word_t'(0);

  // ==========================================================================
  // Control
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state <= S_IDLE;
      req_q <= 1'b0;
      mac_v <= 1'b0;
    end else begin
      req_q <= req;
      mac_v <= state == S_MAC;
      case (state)
        S_IDLE: if (req && !req_q) state <= S_MAC;
        S_MAC:  if (t == conv_size - 1) state <= S_BIAS;
        S_BIAS: state <= S_SUM;
        S_SUM:  state <= S_WR;
        S_WR:   state <= (k == img_size - conv_size) ? S_ACK : S_MAC;
        S_ACK:  if (!req) state <= S_IDLE;
        default: state <= S_IDLE;
      endcase
    end
  end

  // ==========================================================================
  // Datapath
  // ==========================================================================

  always_ff @(posedge clk) begin
    case (state)
      S_IDLE: begin
        k   <= '0;
        t   <= '0;
        acc <= '0;
      end
      S_MAC: t <= t + 1'b1;
      S_SUM: img_wdata <= activate(acc + bias, relu_en);
      S_WR: begin
        t   <= '0;
        k   <= k + 1'b1;
        acc <= '0;
      end
      default: ;
    endcase
    if (mac_v) begin
      acc <= acc + img_rdata * net_rdata;
    end
  end

  // Window must fit inside the image for the whole run
  a_kernel_fits: assert property (@(posedge clk) disable iff (!xrst)
    req |-> conv_size <= img_size);

endmodule

`default_nettype wire

//--- kinpira_top.sv
`timescale 1ns/100ps
`default_nettype none

module kinpira_top (
  input  wire                                    clk,
  input  wire                                    xrst,
  input  wire                                    reg_we,
  input  wire [kinpira_regs_pkg::REG_AWIDTH-1:0] reg_addr,
  input  wire [kinpira_pkg::BWIDTH-1:0]          reg_wdata,
  input  wire                                    net_we,
  input  wire                                    net_core,
  input  wire [kinpira_pkg::GOBOU_NETSIZE-1:0]   net_addr,
  input  wire kinpira_pkg::net_word_t            net_wdata,
  input  wire                                    img_we,
  input  wire kinpira_pkg::img_addr_t            img_addr,
  input  wire kinpira_pkg::img_word_t            img_wdata,
  output logic [kinpira_pkg::BWIDTH-1:0]         reg_rdata,
  output kinpira_pkg::img_word_t                 img_rdata
);
  import kinpira_pkg::*;

  logic which;
  logic which_q;
  logic req;
  logic ack;
  logic eng_own;
  img_addr_t in_offset;
  img_addr_t out_offset;
  img_addr_t net_offset;
  len_t total_out;
  len_t total_in;
  len_t img_size;
  len_t conv_size;
  logic bias_en;
  logic relu_en;

  logic gobou_req;
  logic gobou_ack;
  logic gobou_img_we;
  img_addr_t gobou_img_addr;
  img_word_t gobou_img_wdata;
  logic [GOBOU_NETSIZE-1:0] gobou_net_addr;
  logic gobou_host_we;
  net_word_t gobou_net_rdata;

  logic renkon_req;
  logic renkon_ack;
  logic renkon_img_we;
  img_addr_t renkon_img_addr;
  img_word_t renkon_img_wdata;
  logic [RENKON_NETSIZE-1:0] renkon_net_addr;
  logic renkon_host_we;
  net_word_t renkon_net_rdata;

  logic eng_img_we;
  img_addr_t eng_img_addr;
  img_word_t eng_img_wdata;

  // ==========================================================================
  // Engine select
  // ==========================================================================

  assign gobou_req  = req && which == WHICH_GOBOU;
  assign renkon_req = req && which == WHICH_RENKON;

  assign ack           = (which == WHICH_GOBOU) ? gobou_ack : renkon_ack;
  assign eng_img_we    = (which == WHICH_GOBOU) ? gobou_img_we : renkon_img_we;
  assign eng_img_addr  = (which == WHICH_GOBOU) ? gobou_img_addr : renkon_img_addr;
  assign eng_img_wdata = (which == WHICH_GOBOU) ? gobou_img_wdata : renkon_img_wdata;

  // Engine holds the image buffer from req rise until ack
  assign eng_own = req && !ack;

  assign gobou_host_we  = net_we && net_core == WHICH_GOBOU;
  assign renkon_host_we = net_we && net_core == WHICH_RENKON;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      which_q <= 1'b0;
    end else begin
      which_q <= which;
    end
  end

  // ==========================================================================
  // Registers and memories
  // ==========================================================================

  kinpira_regs regs0 (
    .clk        (clk),
    .xrst       (xrst),
    .reg_we     (reg_we),
    .reg_addr   (reg_addr),
    .reg_wdata  (reg_wdata),
    .ack        (ack),
    .which_q    (which_q),
    .reg_rdata  (reg_rdata),
    .which      (which),
    .req        (req),
    .in_offset  (in_offset),
    .out_offset (out_offset),
    .net_offset (net_offset),
    .total_out  (total_out),
    .total_in   (total_in),
    .img_size   (img_size),
    .conv_size  (conv_size),
    .bias_en    (bias_en),
    .relu_en    (relu_en)
  );

  mem_sp #(.word_t(img_word_t), .AWIDTH(IMGSIZE)) mem_img (
    .clk       (clk),
    .mem_we    (eng_own ? eng_img_we : img_we),
    .mem_addr  (eng_own ? eng_img_addr : img_addr),
    .mem_wdata (eng_own ? eng_img_wdata : img_wdata),
    .mem_rdata (img_rdata)
  );

  mem_sp #(.word_t(net_word_t), .AWIDTH(GOBOU_NETSIZE)) mem_gobou (
    .clk       (clk),
    .mem_we    (gobou_host_we),
    .mem_addr  (gobou_host_we ? net_addr : gobou_net_addr),
    .mem_wdata (net_wdata),
    .mem_rdata (gobou_net_rdata)
  );

  mem_sp #(.word_t(net_word_t), .AWIDTH(RENKON_NETSIZE)) mem_renkon (
    .clk       (clk),
    .mem_we    (renkon_host_we),
    .mem_addr  (renkon_host_we ? net_addr[RENKON_NETSIZE-1:0] : renkon_net_addr),
    .mem_wdata (net_wdata),
    .mem_rdata (renkon_net_rdata)
  );

  // ==========================================================================
  // Engines
  // ==========================================================================

  gobou_core gobou0 (
    .clk        (clk),
    .xrst       (xrst),
    .req        (gobou_req),
    .in_offset  (in_offset),
    .out_offset (out_offset),
    .net_offset (net_offset),
    .total_out  (total_out),
    .total_in   (total_in),
    .bias_en    (bias_en),
    .relu_en    (relu_en),
    .img_rdata  (img_rdata),
    .net_rdata  (gobou_net_rdata),
    .ack        (gobou_ack),
    .img_we     (gobou_img_we),
    .img_addr   (gobou_img_addr),
    .img_wdata  (gobou_img_wdata),
    .net_addr   (gobou_net_addr)
  );

  renkon_core renkon0 (
    .clk        (clk),
    .xrst       (xrst),
    .req        (renkon_req),
    .in_offset  (in_offset),
    .out_offset (out_offset),
    .net_offset (net_offset[RENKON_NETSIZE-1:0]),
    .img_size   (img_size),
    .conv_size  (conv_size),
    .bias_en    (bias_en),
    .relu_en    (relu_en),
    .img_rdata  (img_rdata),
    .net_rdata  (renkon_net_rdata),
    .ack        (renkon_ack),
    .img_we     (renkon_img_we),
    .img_addr   (renkon_img_addr),
    .img_wdata  (renkon_img_wdata),
    .net_addr   (renkon_net_addr)
  );

  a_which_stable: assert property (@(posedge clk) disable iff (!xrst)
    req && $past(req) |-> which == which_q);

endmodule

`default_nettype wire

//--- tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
  parameter int PERIOD     = 20,
  parameter int RST_CYCLES = 3
) (
  output logic clk,
  output logic xrst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Reset leaves on a falling edge like the rest of the stimulus
  initial begin
    xrst = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    xrst = 1'b1;
  end

endmodule

`default_nettype wire

//--- tb_kinpira.sv
`timescale 1ns/100ps
`default_nettype none

module tb_kinpira;
  import kinpira_pkg::*;
  import kinpira_regs_pkg::*;

  // All tests together take roughly 700 cycles
  localparam int MAX_CYCLES = 20000;
  localparam int POLL_LIMIT = 500;

  localparam int G_IN      = 8;
  localparam int G_OUT     = 4;
  localparam int G_IN_OFF  = 16;
  localparam int G_OUT_OFF = 64;
  localparam int G_NET_OFF = 32;
  localparam int G_WORDS   = G_IN * G_OUT + G_OUT;

  localparam int R_IMG     = 16;
  localparam int R_CONV    = 3;
  localparam int R_OUT     = R_IMG - R_CONV + 1;
  localparam int R_IN_OFF  = 128;
  localparam int R_OUT_OFF = 192;
  localparam int R_NET_OFF = 8;

  logic                     clk;
  logic                     xrst;
  logic                     reg_we;
  logic [REG_AWIDTH-1:0]    reg_addr;
  logic [BWIDTH-1:0]        reg_wdata;
  logic [BWIDTH-1:0]        reg_rdata;
  logic                     net_we;
  logic                     net_core;
  logic [GOBOU_NETSIZE-1:0] net_addr;
  net_word_t                net_wdata;
  logic                     img_we;
  img_addr_t                img_addr;
  img_word_t                img_wdata;
  img_word_t                img_rdata;

  // Host side copies of the loaded data
  img_word_t in_g [G_IN];
  net_word_t w_g [G_WORDS];
  img_word_t in_r [R_IMG];
  net_word_t w_r [R_CONV + 1];

  string       cur_test;
  int          test_errs;
  int          total_errs;
  int          tests_run;
  int          tests_failed;
  int          cycles = 0;

  tb_clock #(.PERIOD(20), .RST_CYCLES(3)) clock0 (
    .clk  (clk),
    .xrst (xrst)
  );

  kinpira_top dut0 (
    .clk       (clk),
    .xrst      (xrst),
    .reg_we    (reg_we),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .net_we    (net_we),
    .net_core  (net_core),
    .net_addr  (net_addr),
    .net_wdata (net_wdata),
    .img_we    (img_we),
    .img_addr  (img_addr),
    .img_wdata (img_wdata),
    .reg_rdata (reg_rdata),
    .img_rdata (img_rdata)
  );

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Cycle limit of %0d reached before the tests finished", MAX_CYCLES);
      $display(">>> FAIL");
      $finish;
    end
  end

  // ==========================================================================
  // Host bus access
  // ==========================================================================

  task automatic write_reg(input logic [REG_AWIDTH-1:0] addr, input logic [BWIDTH-1:0] data);
    @(negedge clk);
    reg_we    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge clk);
    reg_we = 1'b0;
  endtask

  task automatic read_reg(input logic [REG_AWIDTH-1:0] addr, output logic [BWIDTH-1:0] data);
    @(negedge clk);
    reg_addr = addr;
    #2;
    data = reg_rdata;
  endtask

  task automatic write_net(input logic core, input logic [GOBOU_NETSIZE-1:0] addr,
                           input net_word_t data);
    @(negedge clk);
    net_we    = 1'b1;
    net_core  = core;
    net_addr  = addr;
    net_wdata = data;
    @(negedge clk);
    net_we = 1'b0;
  endtask

  task automatic write_img(input img_addr_t addr, input img_word_t data);
    @(negedge clk);
    img_we    = 1'b1;
    img_addr  = addr;
    img_wdata = data;
    @(negedge clk);
    img_we = 1'b0;
  endtask

  // Word is registered on the rising edge in between
  task automatic read_img(input img_addr_t addr, output img_word_t data);
    @(negedge clk);
    img_we   = 1'b0;
    img_addr = addr;
    @(negedge clk);
    data = img_rdata;
  endtask

  // ==========================================================================
  // Checks and reporting
  // ==========================================================================

  task automatic check_reg(input string what, input logic [BWIDTH-1:0] exp,
                           input logic [BWIDTH-1:0] got);
    assert (got === exp) else begin
      $display("FAILED %s %s expected %h actual %h", cur_test, what, exp, got);
      test_errs++;
    end
  endtask

  task automatic check_word(input string what, input img_word_t exp, input img_word_t got);
    assert (got === exp) else begin
      $display("FAILED %s %s expected %0d actual %0d", cur_test, what, exp, got);
      test_errs++;
    end
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic finish_test();
    tests_run++;
    total_errs += test_errs;
    if (test_errs == 0) begin
      $display("test %s: ok", cur_test);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", cur_test, test_errs);
    end
  endtask

  // ==========================================================================
  // Reference model
  // ==========================================================================

  function automatic img_word_t rand_word(input int span);
    int v;
    v = int'($urandom_range(2 * span - 1, 0)) - span;
    return v[DWIDTH-1:0];
  endfunction

  function automatic logic [BWIDTH-1:0] enable_word(input bit on);
    return BWIDTH'(on) << ENABLE_BIT;
  endfunction

  function automatic img_word_t scale_out(input longint sum, input bit relu);
    longint scaled;
    scaled = sum >>> FRAC;
    if (relu && scaled[63]) begin
      scaled = 0;
    end
    return scaled[DWIDTH-1:0];
  endfunction

  function automatic img_word_t dense_ref(input int j, input bit bias_on, input bit relu_on);
    longint sum;
    int     i;
    sum = 0;
    for (i = 0; i < G_IN; i++) begin
      sum += longint'(in_g[i]) * longint'(w_g[j * G_IN + i]);
    end
    if (bias_on) begin
      sum += longint'(w_g[G_OUT * G_IN + j]);
    end
    return scale_out(sum, relu_on);
  endfunction

  function automatic img_word_t conv_ref(input int k, input bit bias_on, input bit relu_on);
    longint sum;
    int     t;
    sum = 0;
    for (t = 0; t < R_CONV; t++) begin
      sum += longint'(in_r[k + t]) * longint'(w_r[t]);
    end
    if (bias_on) begin
      sum += longint'(w_r[R_CONV]);
    end
    return scale_out(sum, relu_on);
  endfunction

  // ==========================================================================
  // Engine helpers
  // ==========================================================================

  task automatic run_engine();
    logic [BWIDTH-1:0] stat;
    int                polls;
    write_reg(REG_REQ, 32'd1);
    polls = 0;
    stat  = '0;
    while (stat[0] !== 1'b1 && polls < POLL_LIMIT) begin
      read_reg(REG_STAT_ACK, stat);
      polls++;
    end
    assert (stat[0] === 1'b1) else begin
      $display("Engine gave no ack within %0d polls in test %s", POLL_LIMIT, cur_test);
      test_errs++;
    end
  endtask

  task automatic stop_engine();
    write_reg(REG_REQ, 32'd0);
  endtask

  task automatic setup_gobou(input bit bias_on, input bit relu_on);
    write_reg(REG_WHICH, BWIDTH'(WHICH_GOBOU));
    write_reg(REG_IN_OFFSET, G_IN_OFF);
    write_reg(REG_OUT_OFFSET, G_OUT_OFF);
    write_reg(REG_NET_OFFSET, G_NET_OFF);
    write_reg(REG_BASE0, {16'(G_OUT), 16'(G_IN)});
    write_reg(REG_BIAS, enable_word(bias_on));
    write_reg(REG_ACTV, enable_word(relu_on));
  endtask

  task automatic check_gobou(input bit bias_on, input bit relu_on);
    img_word_t got;
    int        j;
    for (j = 0; j < G_OUT; j++) begin
      read_img(IMGSIZE'(G_OUT_OFF + j), got);
      check_word($sformatf("out[%0d]", j), dense_ref(j, bias_on, relu_on), got);
    end
  endtask

  task automatic check_renkon(input bit bias_on, input bit relu_on);
    img_word_t got;
    int        k;
    for (k = 0; k < R_OUT; k++) begin
      read_img(IMGSIZE'(R_OUT_OFF + k), got);
      check_word($sformatf("out[%0d]", k), conv_ref(k, bias_on, relu_on), got);
    end
  endtask

  task automatic reg_roundtrip(input logic [REG_AWIDTH-1:0] addr,
                               input logic [BWIDTH-1:0] value);
    logic [BWIDTH-1:0] got;
    write_reg(addr, value);
    read_reg(addr, got);
    check_reg($sformatf("reg %0d", addr), value, got);
  endtask

  // ==========================================================================
  // Tests
  // ==========================================================================

  task automatic test_registers();
    logic [BWIDTH-1:0] got;
    start_test("register_readback");
    read_reg(REG_STAT_ACK, got);
    check_reg("ack after reset", '0, got);
    read_reg(REG_STAT_WHICH, got);
    check_reg("which after reset", '0, got);
    read_reg(5'd5, got);
    check_reg("unmapped 5 after reset", '0, got);
    reg_roundtrip(REG_WHICH, $urandom());
    // Bit 0 kept low, a set bit would start an engine
    reg_roundtrip(REG_REQ, $urandom() & 32'hffff_fffe);
    reg_roundtrip(REG_IN_OFFSET, $urandom());
    reg_roundtrip(REG_OUT_OFFSET, $urandom());
    reg_roundtrip(REG_NET_OFFSET, $urandom());
    reg_roundtrip(REG_BASE0, $urandom());
    reg_roundtrip(REG_BASE1, $urandom());
    reg_roundtrip(REG_CONV, $urandom());
    reg_roundtrip(REG_BIAS, $urandom());
    reg_roundtrip(REG_ACTV, $urandom());
    write_reg(5'd5, $urandom());
    read_reg(5'd5, got);
    check_reg("unmapped 5 after write", '0, got);
    read_reg(5'd20, got);
    check_reg("unmapped 20", '0, got);
    finish_test();
  endtask

  task automatic test_gobou_dense();
    int n;
    start_test("gobou_dense");
    for (n = 0; n < G_IN; n++) begin
      in_g[n] = rand_word(256);
      write_img(IMGSIZE'(G_IN_OFF + n), in_g[n]);
    end
    for (n = 0; n < G_WORDS; n++) begin
      w_g[n] = rand_word(256);
      write_net(WHICH_GOBOU, GOBOU_NETSIZE'(G_NET_OFF + n), w_g[n]);
    end
    setup_gobou(1'b1, 1'b1);
    run_engine();
    stop_engine();
    check_gobou(1'b1, 1'b1);
    finish_test();
  endtask

  task automatic test_gobou_linear();
    img_word_t got;
    int        n;
    start_test("gobou_no_bias_no_relu");
    // Row 0 against the negated input gives a negative sum
    for (n = 0; n < G_IN; n++) begin
      w_g[n] = -in_g[n];
      write_net(WHICH_GOBOU, GOBOU_NETSIZE'(G_NET_OFF + n), w_g[n]);
    end
    setup_gobou(1'b0, 1'b0);
    run_engine();
    stop_engine();
    check_gobou(1'b0, 1'b0);
    read_img(IMGSIZE'(G_OUT_OFF), got);
    assert (got < 0) else begin
      $display("Output 0 of test %s is not negative, so it was clamped", cur_test);
      test_errs++;
    end
    finish_test();
  endtask

  task automatic test_renkon_conv();
    int n;
    start_test("renkon_conv");
    for (n = 0; n < R_IMG; n++) begin
      in_r[n] = rand_word(256);
      write_img(IMGSIZE'(R_IN_OFF + n), in_r[n]);
    end
    for (n = 0; n <= R_CONV; n++) begin
      w_r[n] = rand_word(256);
      write_net(WHICH_RENKON, GOBOU_NETSIZE'(R_NET_OFF + n), w_r[n]);
    end
    write_reg(REG_WHICH, BWIDTH'(WHICH_RENKON));
    write_reg(REG_IN_OFFSET, R_IN_OFF);
    write_reg(REG_OUT_OFFSET, R_OUT_OFF);
    write_reg(REG_NET_OFFSET, R_NET_OFF);
    write_reg(REG_BASE1, {16'd0, 16'(R_IMG)});
    write_reg(REG_CONV, {16'(R_CONV), 16'd0});
    write_reg(REG_BIAS, enable_word(1'b1));
    write_reg(REG_ACTV, enable_word(1'b1));
    run_engine();
    stop_engine();
    check_renkon(1'b1, 1'b1);
    finish_test();
  endtask

  task automatic test_engine_select();
    logic [BWIDTH-1:0] got;
    int                n;
    start_test("engine_select");
    write_reg(REG_WHICH, BWIDTH'(WHICH_GOBOU));
    read_reg(REG_STAT_WHICH, got);
    check_reg("status which gobou", BWIDTH'(WHICH_GOBOU), got);
    write_reg(REG_WHICH, BWIDTH'(WHICH_RENKON));
    read_reg(REG_STAT_WHICH, got);
    check_reg("status which renkon", BWIDTH'(WHICH_RENKON), got);
    // Stale outputs must be overwritten by the new run
    for (n = 0; n < R_OUT; n++) begin
      write_img(IMGSIZE'(R_OUT_OFF + n), 16'sh5a5a);
    end
    for (n = 0; n <= R_CONV; n++) begin
      write_net(WHICH_GOBOU, GOBOU_NETSIZE'(R_NET_OFF + n), rand_word(256));
    end
    run_engine();
    read_reg(REG_STAT_ACK, got);
    check_reg("status ack while req high", 32'd1, got);
    stop_engine();
    read_reg(REG_STAT_ACK, got);
    check_reg("status ack after req drop", 32'd0, got);
    check_renkon(1'b1, 1'b1);
    finish_test();
  endtask

  // ==========================================================================
  // Main sequence
  // ==========================================================================

  initial begin
    reg_we       = 1'b0;
    reg_addr     = '0;
    reg_wdata    = '0;
    net_we       = 1'b0;
    net_core     = 1'b0;
    net_addr     = '0;
    net_wdata    = '0;
    img_we       = 1'b0;
    img_addr     = '0;
    img_wdata    = '0;
    test_errs    = 0;
    total_errs   = 0;
    tests_run    = 0;
    tests_failed = 0;
    void'($urandom(51));

    @(posedge xrst);
    repeat (2) @(negedge clk);

    test_registers();
    test_gobou_dense();
    test_gobou_linear();
    test_renkon_conv();
    test_engine_select();

    $display("tests run %0d, tests failed %0d, checks failed %0d",
             tests_run, tests_failed, total_errs);
    if (total_errs == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
kinpira_pkg.sv
kinpira_regs_pkg.sv
mem_sp.sv
kinpira_regs.sv
gobou_core.sv
renkon_core.sv
kinpira_top.sv
tb_clock.sv
tb_kinpira.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_kinpira \
  -f build.f -o sim_tb > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Build failed"
  exit 1
fi

./obj_dir/sim_tb > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q ">>> FAIL" "$SIM_LOG"; then
  exit 1
fi
if ! grep -q ">>> PASS" "$SIM_LOG"; then
  echo "Simulation ended without a result"
  exit 1
fi
exit 0
